// File: project.f
source/fifo_pkg.sv
source/fifo_ptr_counter.sv
source/fifo_control.sv
source/fifo_mem.sv
source/gaxi_fifo_sync.sv
sim/gaxi_fifo_sync_props.sv
sim/tb_gaxi_fifo_sync.sv

// File: run_sim.sh
#!/bin/sh
# Build the FIFO testbench with Verilator, run it, and scan the log.
# A failed build or run adds the fail line, so the search below sees it.
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --assert -j 0 --top-module tb_gaxi_fifo_sync -f project.f -o vsim \
        > build.log 2>&1 \
        && ./obj_dir/vsim > "$LOG" 2>&1 \
        || echo "** FAIL **" >> "$LOG"

cat "$LOG"
grep -qF "** FAIL **" "$LOG" && exit 1
exit 0

// File: sim/gaxi_fifo_sync_props.sv
/*
 * Concurrent assertions for the synchronous FIFO, bound to the top level
 * Flag, count, back-pressure and latency rules
 */

`timescale 1ns/1ps
`default_nettype none

module gaxi_fifo_sync_props import fifo_pkg::*; (
        input  wire logic                   i_axi_aclk,
        input  wire logic                   i_axi_aresetn,
        input  wire logic                   i_wr_valid,
        input  wire logic                   i_wr_ready,
        input  wire logic                   i_rd_valid,
        input  wire logic                   i_rd_ready,
        input  wire logic [DATA_WIDTH-1:0]  i_rd_data,
        input  wire logic [COUNT_WIDTH-1:0] i_count,
        input  wire logic                   i_almost_full,
        input  wire logic                   i_almost_empty
);

        localparam logic [COUNT_WIDTH-1:0] CNT_DEPTH  = COUNT_WIDTH'(DEPTH);
        localparam logic [COUNT_WIDTH-1:0] CNT_AF_MIN = COUNT_WIDTH'(DEPTH - ALMOST_WR_MARGIN);
        localparam logic [COUNT_WIDTH-1:0] CNT_AE_MAX = COUNT_WIDTH'(ALMOST_RD_MARGIN);
        localparam logic [COUNT_WIDTH-1:0] CNT_ONE    = COUNT_WIDTH'(1);

        logic w_wr_hs;
        logic w_rd_hs;

        assign w_wr_hs = i_wr_valid && i_wr_ready;
        assign w_rd_hs = i_rd_valid && i_rd_ready;

        // ------------------------------------------------------------------
        // Flags follow the count
        // ------------------------------------------------------------------
        handshake_flags: assert property (@(posedge i_axi_aclk) disable iff (!i_axi_aresetn)
                (i_wr_ready == (i_count < CNT_DEPTH)) && (i_rd_valid == (i_count != '0)))
                else $error("Ready or valid disagrees with the occupancy count");

        almost_flags: assert property (@(posedge i_axi_aclk) disable iff (!i_axi_aresetn)
                (i_almost_full == (i_count >= CNT_AF_MIN))
                && (i_almost_empty == (i_count <= CNT_AE_MAX)))
                else $error("Almost flags disagree with the occupancy count");

        // Up one on write only, down one on read only
        count_step: assert property (@(posedge i_axi_aclk) disable iff (!i_axi_aresetn)
                $past(i_axi_aresetn) |-> i_count == $past(i_count)
                        + COUNT_WIDTH'($past(w_wr_hs)) - COUNT_WIDTH'($past(w_rd_hs)))
                else $error("Occupancy count stepped wrongly");

        // ------------------------------------------------------------------
        // Back-pressure and latency
        // ------------------------------------------------------------------
        head_held: assert property (@(posedge i_axi_aclk) disable iff (!i_axi_aresetn)
                $past(i_axi_aresetn && i_rd_valid && !i_rd_ready)
                        |-> i_rd_valid && (i_rd_data == $past(i_rd_data)))
                else $error("Head word changed while the sink stalled");

        full_stall: assert property (@(posedge i_axi_aclk) disable iff (!i_axi_aresetn)
                $past(i_axi_aresetn && !i_wr_ready && !i_rd_ready) |-> i_count == CNT_DEPTH)
                else $error("Full FIFO lost its occupancy while stalled");

        first_word: assert property (@(posedge i_axi_aclk) disable iff (!i_axi_aresetn)
                $past(i_axi_aresetn && !i_rd_valid && w_wr_hs) |-> i_rd_valid)
                else $error("Valid did not rise one cycle after a write into an empty FIFO");

        last_word: assert property (@(posedge i_axi_aclk) disable iff (!i_axi_aresetn)
                $past(i_axi_aresetn && (i_count == CNT_ONE) && w_rd_hs && !w_wr_hs)
                        |-> !i_rd_valid)
                else $error("Valid stayed high after the last word was read");

endmodule : gaxi_fifo_sync_props

bind gaxi_fifo_sync gaxi_fifo_sync_props gaxi_fifo_sync_props_i (
        .i_axi_aclk     (i_axi_aclk),
        .i_axi_aresetn  (i_axi_aresetn),
        .i_wr_valid     (i_wr_valid),
        .i_wr_ready     (o_wr_ready),
        .i_rd_valid     (o_rd_valid),
        .i_rd_ready     (i_rd_ready),
        .i_rd_data      (o_rd_data),
        .i_count        (o_count),
        .i_almost_full  (o_almost_full),
        .i_almost_empty (o_almost_empty)
);

`default_nettype wire

// File: sim/tb_gaxi_fifo_sync.sv
/*
 * Testbench for the synchronous valid/ready FIFO
 * LFSR stimulus in phases, reference queue, data-order and reset checks
 */

`timescale 1ns/1ps
`default_nettype none

module tb_gaxi_fifo_sync import fifo_pkg::*; ();

        // Wait loop limit in cycles
        localparam int          WAIT_LIMIT   = 64;
        // Length of each random phase
        localparam int          PHASE_CYCLES = 240;
        localparam logic [15:0] LFSR_SEED    = 16'd52197;
        // Galois taps for x^16 + x^14 + x^13 + x^11 + 1
        localparam logic [15:0] LFSR_TAPS    = 16'hB400;

        logic                   axi_aclk = 1'b0;
        logic                   axi_aresetn;
        logic                   wr_valid;
        logic [DATA_WIDTH-1:0]  wr_data;
        logic                   wr_ready;
        logic                   rd_valid;
        logic [DATA_WIDTH-1:0]  rd_data;
        logic                   rd_ready;
        logic [COUNT_WIDTH-1:0] count;
        logic                   almost_full;
        logic                   almost_empty;

        logic [15:0]            lfsr_state = LFSR_SEED;
        // Words accepted at the ports and not yet handed off
        logic [DATA_WIDTH-1:0]  ref_q [$];
        int                     cycles;

        gaxi_fifo_sync gaxi_fifo_sync_i (
                .i_axi_aclk     (axi_aclk),
                .i_axi_aresetn  (axi_aresetn),
                .i_wr_valid     (wr_valid),
                .i_wr_data      (wr_data),
                .o_wr_ready     (wr_ready),
                .o_rd_valid     (rd_valid),
                .o_rd_data      (rd_data),
                .i_rd_ready     (rd_ready),
                .o_count        (count),
                .o_almost_full  (almost_full),
                .o_almost_empty (almost_empty)
        );

        // 100 ns period
        always #50 axi_aclk = ~axi_aclk;

        // ------------------------------------------------------------------
        // Random source and checking helpers
        // ------------------------------------------------------------------
        function automatic logic [15:0] lfsr_next(input logic [15:0] s);
                return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
        endfunction

        // One LFSR step per bit taken
        function automatic logic [15:0] take_bits(input int n);
                logic [15:0] bits;
                bits = '0;
                for (int k = 0; k < n; k++) begin
                        bits = {bits[14:0], lfsr_state[0]};
                        lfsr_state = lfsr_next(lfsr_state);
                end
                return bits;
        endfunction

        // True with probability quarters/4
        function automatic logic chance(input int quarters);
                return take_bits(2) < 16'(quarters);
        endfunction

        task automatic stop_on_failure();
                $display("** FAIL **");
                $fatal(1, "Simulation stopped at the first failure");
        endtask

        task automatic check_equal(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                assert (got === exp) else begin
                        $display("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp);
                        stop_on_failure();
                end
        endtask

        task automatic check_wait(input int spent, input string what);
                assert (spent < WAIT_LIMIT) else begin
                        $display("Timeout while waiting for %s", what);
                        stop_on_failure();
                end
        endtask

        task automatic check_reset_state();
                check_equal("o_rd_valid", 32'(rd_valid), 32'd0);
                check_equal("o_wr_ready", 32'(wr_ready), 32'd1);
                check_equal("o_count", 32'(count), 32'd0);
                check_equal("o_almost_empty", 32'(almost_empty), 32'd1);
                check_equal("o_almost_full", 32'(almost_full), 32'd0);
        endtask

        // Drive at edge + 1 ns, check mid-cycle, track handshakes at the edge
        task automatic run_cycle(input logic wr_v, input logic rd_r);
                logic wr_hs;
                logic rd_hs;
                wr_valid = wr_v;
                rd_ready = rd_r;
                wr_data  = DATA_WIDTH'(take_bits(DATA_WIDTH));
                @(negedge axi_aclk);
                check_equal("o_count", 32'(count), 32'(ref_q.size()));
                if (rd_valid) begin
                        assert (ref_q.size() > 0) else begin
                                $display("Read side shows data with nothing written");
                                stop_on_failure();
                        end
                        check_equal("o_rd_data", 32'(rd_data), 32'(ref_q[0]));
                end
                wr_hs = wr_valid && wr_ready;
                rd_hs = rd_valid && rd_ready;
                @(posedge axi_aclk);
                if (rd_hs) void'(ref_q.pop_front());
                if (wr_hs) ref_q.push_back(wr_data);
                #1;
        endtask

        task automatic run_random_phase(input int wr_quarters, input int rd_quarters);
                for (int n = 0; n < PHASE_CYCLES; n++) begin
                        run_cycle(chance(wr_quarters), chance(rd_quarters));
                end
        endtask

        task automatic drain_all();
                cycles = 0;
                while (rd_valid) begin
                        check_wait(cycles, "o_rd_valid to fall while draining");
                        run_cycle(1'b0, 1'b1);
                        cycles++;
                end
                run_cycle(1'b0, 1'b0);
        endtask

        // ------------------------------------------------------------------
        // Main sequence
        // ------------------------------------------------------------------
        initial begin
                axi_aresetn = 1'b0;
                wr_valid    = 1'b0;
                wr_data     = '0;
                rd_ready    = 1'b0;

                // Reset low across 8 rising edges
                repeat (8) begin
                        @(posedge axi_aclk);
                        #1;
                        check_reset_state();
                end
                axi_aresetn = 1'b1;
                @(negedge axi_aclk);
                check_reset_state();
                @(posedge axi_aclk);
                #1;

                // Fill only, head held with rd_ready low
                cycles = 0;
                while (wr_ready) begin
                        check_wait(cycles, "o_wr_ready to fall while filling");
                        run_cycle(1'b1, 1'b0);
                        cycles++;
                end
                // Writes stall while full
                repeat (4) run_cycle(1'b1, 1'b0);
                check_equal("o_count", 32'(count), 32'(DEPTH));

                // Drain only
                drain_all();

                // First word visible one cycle after acceptance
                run_cycle(1'b1, 1'b0);
                check_equal("o_rd_valid", 32'(rd_valid), 32'd1);
                check_equal("o_rd_data", 32'(rd_data), 32'(ref_q[0]));
                // Reading the last word clears valid
                run_cycle(1'b0, 1'b1);
                check_equal("o_rd_valid", 32'(rd_valid), 32'd0);

                // Balanced, write-heavy, read-heavy
                run_random_phase(2, 2);
                run_random_phase(3, 1);
                run_random_phase(1, 3);
                drain_all();

                $display("** PASS **");
                $finish;
        end

endmodule : tb_gaxi_fifo_sync

`default_nettype wire

// File: source/fifo_control.sv
/*
 * FIFO control with handshake gating and enable generation
 * Registered occupancy, full, empty and almost flags
 */

`timescale 1ns/1ps
`default_nettype none

module fifo_control import fifo_pkg::*; (
        input  wire logic                   i_axi_aclk,
        input  wire logic                   i_axi_aresetn,
        input  wire logic                   i_wr_valid,
        input  wire logic                   i_rd_ready,
        input  wire logic [PTR_WIDTH-1:0]   i_wr_ptr_next,
        input  wire logic [PTR_WIDTH-1:0]   i_rd_ptr_next,
        output logic                        o_wr_en,
        output logic                        o_rd_en,
        output logic                        o_wr_ready,
        output logic                        o_rd_valid,
        output logic [COUNT_WIDTH-1:0]      o_count,
        output logic                        o_almost_full,
        output logic                        o_almost_empty
);

        // Flag thresholds in count width
        localparam logic [COUNT_WIDTH-1:0] CNT_DEPTH   = COUNT_WIDTH'(DEPTH);
        localparam logic [COUNT_WIDTH-1:0] CNT_AF_MIN  =
                COUNT_WIDTH'(DEPTH - ALMOST_WR_MARGIN);
        localparam logic [COUNT_WIDTH-1:0] CNT_AE_MAX  = COUNT_WIDTH'(ALMOST_RD_MARGIN);

        // ------------------------------------------------------------------
        // Pointer fields and next state
        // ------------------------------------------------------------------
        logic [ADDR_WIDTH-1:0]  w_wr_addr;
        logic [ADDR_WIDTH-1:0]  w_rd_addr;
        logic                   w_wr_wrap;
        logic                   w_rd_wrap;
        logic [COUNT_WIDTH-1:0] w_count;
        logic                   w_full;
        logic                   w_empty;

        logic [COUNT_WIDTH-1:0] r_count;
        logic                   r_full;
        logic                   r_empty;
        logic                   r_almost_full;
        logic                   r_almost_empty;

        assign w_wr_addr = i_wr_ptr_next[ADDR_WIDTH-1:0];
        assign w_rd_addr = i_rd_ptr_next[ADDR_WIDTH-1:0];
        assign w_wr_wrap = i_wr_ptr_next[PTR_WIDTH-1];
        assign w_rd_wrap = i_rd_ptr_next[PTR_WIDTH-1];

        // Occupancy from the pointers after this edge
        always_comb begin
                if (w_wr_wrap == w_rd_wrap) begin
                        // Same lap, plain difference
                        w_count = COUNT_WIDTH'(w_wr_addr) - COUNT_WIDTH'(w_rd_addr);
                end else begin
                        // Writer one lap ahead
                        w_count = CNT_DEPTH - COUNT_WIDTH'(w_rd_addr)
                                + COUNT_WIDTH'(w_wr_addr);
                end
        end

        // Same address on different laps means full
        assign w_full  = (w_wr_addr == w_rd_addr) && (w_wr_wrap != w_rd_wrap);
        // Identical pointers means empty
        assign w_empty = (i_wr_ptr_next == i_rd_ptr_next);

        // ------------------------------------------------------------------
        // Flag and count registers
        // ------------------------------------------------------------------
        always_ff @(posedge i_axi_aclk) begin
                if (!i_axi_aresetn) begin
                        r_count        <= '0;
                        r_full         <= 1'b0;
                        r_empty        <= 1'b1;
                        r_almost_full  <= 1'b0;
                        r_almost_empty <= 1'b1;
                end else begin
                        r_count        <= w_count;
                        r_full         <= w_full;
                        r_empty        <= w_empty;
                        r_almost_full  <= (w_count >= CNT_AF_MIN);
                        r_almost_empty <= (w_count <= CNT_AE_MAX);
                end
        end

        // Enables only when the handshake can complete
        assign o_wr_en = i_wr_valid && !r_full;
        assign o_rd_en = i_rd_ready && !r_empty;

        // Handshake side of the flags
        assign o_wr_ready     = !r_full;
        assign o_rd_valid     = !r_empty;
        assign o_count        = r_count;
        assign o_almost_full  = r_almost_full;
        assign o_almost_empty = r_almost_empty;

endmodule : fifo_control

`default_nettype wire

// File: source/fifo_mem.sv
/*
 * FIFO storage array
 * Clocked write port, combinational look-ahead read port
 */

`timescale 1ns/1ps
`default_nettype none

module fifo_mem import fifo_pkg::*; (
        input  wire logic                    i_axi_aclk,
        input  wire logic                    i_wr_en,
        input  wire logic [ADDR_WIDTH-1:0]   i_wr_addr,
        input  wire logic [DATA_WIDTH-1:0]   i_wr_data,
        input  wire logic [ADDR_WIDTH-1:0]   i_rd_addr,
        output logic [DATA_WIDTH-1:0]        o_rd_data
);

        // ------------------------------------------------------------------
        // Storage
        // ------------------------------------------------------------------

        // One word per entry, contents undefined until written
        logic [DATA_WIDTH-1:0] mem [DEPTH];

        // Write port
        always_ff @(posedge i_axi_aclk) begin
                if (i_wr_en) begin
                        mem[i_wr_addr] <= i_wr_data;
                end
        end

        // ------------------------------------------------------------------
        // Read port
        // ------------------------------------------------------------------

        // Head word shows up as soon as the read pointer moves
        // Address stays below DEPTH by construction of the pointers
        always_comb begin
                o_rd_data = mem[i_rd_addr];
        end

endmodule : fifo_mem

`default_nettype wire

// File: source/fifo_pkg.sv
/*
 * Shared sizes for the synchronous valid/ready FIFO
 * Data width, depth, pointer and count widths, almost margins
 */

`default_nettype none

package fifo_pkg;

        // ------------------------------------------------------------------
        // Storage geometry
        // ------------------------------------------------------------------

        // Width of one stored word
        localparam int DATA_WIDTH = 8;

        // Entry count, not a power of two on purpose
        localparam int DEPTH = 6;

        // Address bits needed to index DEPTH entries
        localparam int ADDR_WIDTH = $clog2(DEPTH);

        // Address plus one wrap bit
        localparam int PTR_WIDTH = ADDR_WIDTH + 1;

        // Occupancy must reach DEPTH itself
        localparam int COUNT_WIDTH = PTR_WIDTH;

        // ------------------------------------------------------------------
        // Almost flag thresholds
        // ------------------------------------------------------------------

        // Almost full at DEPTH - margin and above
        localparam int ALMOST_WR_MARGIN = 1;

        // Almost empty at margin and below
        localparam int ALMOST_RD_MARGIN = 1;

endpackage : fifo_pkg

`default_nettype wire

// File: source/fifo_ptr_counter.sv
/*
 * Binary FIFO pointer that wraps at DEPTH
 * Address part plus wrap bit, current and next values
 */

`timescale 1ns/1ps
`default_nettype none

module fifo_ptr_counter import fifo_pkg::*; (
        input  wire logic                 i_axi_aclk,
        input  wire logic                 i_axi_aresetn,
        input  wire logic                 i_enable,
        output logic [PTR_WIDTH-1:0]      o_ptr_curr,
        output logic [PTR_WIDTH-1:0]      o_ptr_next
);

        // Last valid address before the wrap
        localparam logic [ADDR_WIDTH-1:0] ADDR_LAST = ADDR_WIDTH'(DEPTH - 1);

        logic [PTR_WIDTH-1:0]  r_ptr;
        logic [ADDR_WIDTH-1:0] w_addr;
        logic                  w_wrap;

        // Split pointer into address and wrap bit
        assign w_addr = r_ptr[ADDR_WIDTH-1:0];
        assign w_wrap = r_ptr[PTR_WIDTH-1];

        // Next value, hold when idle
        always_comb begin
                o_ptr_next = r_ptr;
                if (i_enable) begin
                        if (w_addr == ADDR_LAST) begin
                                // Back to address zero, flip the lap
                                o_ptr_next = {~w_wrap, {ADDR_WIDTH{1'b0}}};
                        end else begin
                                o_ptr_next = {w_wrap, w_addr + ADDR_WIDTH'(1)};
                        end
                end
        end

        // Pointer register
        always_ff @(posedge i_axi_aclk) begin
                if (!i_axi_aresetn) begin
                        r_ptr <= '0;
                end else begin
                        r_ptr <= o_ptr_next;
                end
        end

        assign o_ptr_curr = r_ptr;

endmodule : fifo_ptr_counter

`default_nettype wire

// File: source/gaxi_fifo_sync.sv
/*
 * Synchronous valid/ready FIFO top level for any depth
 * Control block, write and read pointers, look-ahead storage
 */

`timescale 1ns/1ps
`default_nettype none

module gaxi_fifo_sync import fifo_pkg::*; (
        input  wire logic                    i_axi_aclk,
        input  wire logic                    i_axi_aresetn,
        // Write side
        input  wire logic                    i_wr_valid,
        input  wire logic [DATA_WIDTH-1:0]   i_wr_data,
        output logic                         o_wr_ready,
        // Read side
        output logic                         o_rd_valid,
        output logic [DATA_WIDTH-1:0]        o_rd_data,
        input  wire logic                    i_rd_ready,
        // Status
        output logic [COUNT_WIDTH-1:0]       o_count,
        output logic                         o_almost_full,
        output logic                         o_almost_empty
);

        // ------------------------------------------------------------------
        // Internal wires
        // ------------------------------------------------------------------
        logic                 w_wr_en;
        logic                 w_rd_en;
        logic [PTR_WIDTH-1:0] w_wr_ptr_curr;
        logic [PTR_WIDTH-1:0] w_wr_ptr_next;
        logic [PTR_WIDTH-1:0] w_rd_ptr_curr;
        logic [PTR_WIDTH-1:0] w_rd_ptr_next;

        // Handshake gating, flags and count
        fifo_control fifo_control_i (
                .i_axi_aclk     (i_axi_aclk),
                .i_axi_aresetn  (i_axi_aresetn),
                .i_wr_valid     (i_wr_valid),
                .i_rd_ready     (i_rd_ready),
                .i_wr_ptr_next  (w_wr_ptr_next),
                .i_rd_ptr_next  (w_rd_ptr_next),
                .o_wr_en        (w_wr_en),
                .o_rd_en        (w_rd_en),
                .o_wr_ready     (o_wr_ready),
                .o_rd_valid     (o_rd_valid),
                .o_count        (o_count),
                .o_almost_full  (o_almost_full),
                .o_almost_empty (o_almost_empty)
        );

        // Write pointer, steps on each accepted word
        fifo_ptr_counter write_ptr_i (
                .i_axi_aclk    (i_axi_aclk),
                .i_axi_aresetn (i_axi_aresetn),
                .i_enable      (w_wr_en),
                .o_ptr_curr    (w_wr_ptr_curr),
                .o_ptr_next    (w_wr_ptr_next)
        );

        // Read pointer, steps on each word handed off
        fifo_ptr_counter read_ptr_i (
                .i_axi_aclk    (i_axi_aclk),
                .i_axi_aresetn (i_axi_aresetn),
                .i_enable      (w_rd_en),
                .o_ptr_curr    (w_rd_ptr_curr),
                .o_ptr_next    (w_rd_ptr_next)
        );

        // Storage addressed by the pointer address bits
        fifo_mem fifo_mem_i (
                .i_axi_aclk (i_axi_aclk),
                .i_wr_en    (w_wr_en),
                .i_wr_addr  (w_wr_ptr_curr[ADDR_WIDTH-1:0]),
                .i_wr_data  (i_wr_data),
                .i_rd_addr  (w_rd_ptr_curr[ADDR_WIDTH-1:0]),
                .o_rd_data  (o_rd_data)
        );

endmodule : gaxi_fifo_sync

`default_nettype wire
